// File: sim.f
hdl/fp64_pkg.sv
hdl/fp_decomp64.sv
hdl/fp_compare64.sv
hdl/fp_result_fifo.sv
hdl/fp_except_status.sv
hdl/fp_cmp_unit.sv
tb/tb_clock_gen.sv
tb/fp_cmp_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it into sim.log and checks the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fp_cmp_tb -f sim.f -o fp_cmp_sim > build.log 2>&1 &&
	./obj_dir/fp_cmp_sim > sim.log 2>&1 ||
	{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "Everything OK" sim.log &&
	{ echo "PASS"; exit 0; } ||
	{ echo "FAIL"; exit 1; }

// File: tb/fp_cmp_tb.sv
// directed tests of fp_cmp_unit with FIFO_DEPTH 4 and OUT_CREDITS 2; outputs sampled on falling edge
`timescale 1ns/1ns
`default_nettype none

module fp_cmp_tb;
	import fp64_pkg::*;

	localparam int FIFO_DEPTH  = 4;
	localparam int OUT_CREDITS = 2;
	localparam int N_RANDOM    = 16;
	// random pairs plus 7 zero, 3 nan and 6 back-pressure operations
	localparam int TOTAL_OPS   = N_RANDOM + 16;
	localparam int WATCHDOG_NS = (16 + TOTAL_OPS * 20 + 200) * 40;
	localparam int unsigned RAND_SEED = 32'he242b311;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic [FP_WIDTH-1:0]   a;
	logic [FP_WIDTH-1:0]   b;
	logic                  out_credit;
	logic                  status_clear;
	logic                  in_credit;
	logic                  out_valid;
	logic [COND_WIDTH-1:0] out_cond;
	logic                  out_nan;
	logic                  out_snan;
	logic                  nan_sticky;
	logic                  snan_sticky;

	// scoreboard entry is {snan, nan, cond}
	logic [COND_WIDTH+1:0] sb [$];
	logic [COND_WIDTH+1:0] exp_word;
	int err_count = 0;
	int check_count = 0;
	int sent_count = 0;
	int credit_pulses = 0;
	int out_count = 0;
	int returned_count = 0;
	// consumer hands back one credit per consumed result while set
	logic auto_credit;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) clock_gen_i (.clk(clk), .reset(reset));

	fp_cmp_unit #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) fp_cmp_unit_i (.clk(clk),
		.reset(reset), .in_valid(in_valid), .a(a), .b(b), .out_credit(out_credit),
		.status_clear(status_clear), .in_credit(in_credit), .out_valid(out_valid),
		.out_cond(out_cond), .out_nan(out_nan), .out_snan(out_snan),
		.nan_sticky(nan_sticky), .snan_sticky(snan_sticky));

	// ========================================
	// reference model and helpers
	// ========================================
	function automatic logic [COND_WIDTH+1:0] ref_result(input logic [63:0] x,
		input logic [63:0] y);
		logic nx, ny, zx, zy, un, eq, lt, mlt, mgt, sn;
		logic [COND_WIDTH-1:0] c;
		// ieee binary64: sign 63, exponent 62:52, fraction 51:0
		nx = (&x[62:52]) & (|x[51:0]);
		ny = (&y[62:52]) & (|y[51:0]);
		zx = ~|x[62:0];
		zy = ~|y[62:0];
		// signaling nan has a clear fraction msb
		sn = (nx & ~x[51]) | (ny & ~y[51]);
		un = nx | ny;
		eq = ~un & ((zx & zy) | (x == y));
		mlt = x[62:0] < y[62:0];
		mgt = x[62:0] > y[62:0];
		if (x[63] != y[63])
			lt = x[63] & ~(zx & zy);
		else
			lt = x[63] ? mgt : mlt;
		c = '0;
		c[COND_EQ]  = eq;
		c[COND_LT]  = lt;
		c[COND_LE]  = lt | eq;
		c[COND_MLT] = mlt;
		c[COND_UN]  = un;
		c[COND_INV_OFS + COND_EQ]  = ~eq;
		c[COND_INV_OFS + COND_LT]  = ~lt;
		c[COND_INV_OFS + COND_LE]  = ~(lt | eq);
		c[COND_INV_OFS + COND_MLT] = ~mlt;
		c[COND_INV_OFS + COND_UN]  = ~un;
		return {sn, un, c};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
			err_count++;
		end
	endtask

	// producer side, only sends while an upstream credit is held
	task automatic send_pair(input logic [63:0] x, input logic [63:0] y);
		while (FIFO_DEPTH - sent_count + credit_pulses <= 0)
		begin
			@(posedge clk);
			#2;
		end
		a = x;
		b = y;
		in_valid = 1'b1;
		sent_count++;
		sb.push_back(ref_result(x, y));
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	// hand-derived word checked against the model before sending
	task automatic send_known(input logic [63:0] x, input logic [63:0] y,
		input logic [COND_WIDTH+1:0] expected);
		logic [COND_WIDTH+1:0] r;
		r = ref_result(x, y);
		check_value("reference word", 32'(r), 32'(expected));
		send_pair(x, y);
	endtask

	task automatic wait_drain();
		while (sb.size() != 0 || out_count != returned_count)
		begin
			@(posedge clk);
			#2;
		end
		repeat (2) @(posedge clk);
		#2;
	endtask

	task automatic pulse_clear();
		status_clear = 1'b1;
		@(posedge clk);
		#2;
		status_clear = 1'b0;
		@(posedge clk);
		#2;
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic run_random();
		logic [63:0] x, y;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			x = {$urandom, $urandom};
			// equal, one ulp apart and sign-flipped partners
			case (i % 4)
				0: y = {$urandom, $urandom};
				1: y = x;
				2: y = x ^ 64'h1;
				default: y = {~x[63], x[62:0]};
			endcase
			send_pair(x, y);
		end
		wait_drain();
	endtask

	task automatic run_zeros();
		send_known(64'h0, 64'h8000000000000000, {2'b00, 16'h1A05});
		send_known(64'h3FF0000000000000, 64'h3FF0000000000000, {2'b00, 16'h1A05});
		send_known(64'hBFF0000000000000, 64'h0, {2'b00, 16'h1906});
		// -1 vs 2 is smaller in magnitude too, -2 vs 1 is not
		send_known(64'hBFF0000000000000, 64'h4000000000000000, {2'b00, 16'h110E});
		send_known(64'hC000000000000000, 64'h3FF0000000000000, {2'b00, 16'h1906});
		send_known(64'hC000000000000000, 64'hBFF0000000000000, {2'b00, 16'h1906});
		send_known(64'h4000000000000000, 64'h3FF0000000000000, {2'b00, 16'h1F00});
		wait_drain();
	endtask

	task automatic run_nans();
		pulse_clear();
		check_value("nan_sticky", 32'(nan_sticky), 32'h0);
		check_value("snan_sticky", 32'(snan_sticky), 32'h0);
		send_known(64'h7FF8000000000000, 64'h3FF0000000000000, {2'b01, 16'h0F10});
		wait_drain();
		check_value("nan_sticky", 32'(nan_sticky), 32'h1);
		check_value("snan_sticky", 32'(snan_sticky), 32'h0);
		send_known(64'h7FF0000000000001, 64'h3FF0000000000000, {2'b11, 16'h0F10});
		wait_drain();
		check_value("snan_sticky", 32'(snan_sticky), 32'h1);
		// ordered compare leaves both flags set
		send_known(64'h3FF0000000000000, 64'h4000000000000000, {2'b00, 16'h110E});
		wait_drain();
		check_value("nan_sticky", 32'(nan_sticky), 32'h1);
		check_value("snan_sticky", 32'(snan_sticky), 32'h1);
		pulse_clear();
		check_value("nan_sticky", 32'(nan_sticky), 32'h0);
		check_value("snan_sticky", 32'(snan_sticky), 32'h0);
	endtask

	task automatic run_backpressure();
		int base_out;
		int base_pulses;
		auto_credit = 1'b0;
		base_out = out_count;
		// two leave on the initial credit, four stay in the FIFO
		for (int i = 0; i < 6; i++)
			send_pair({$urandom, $urandom}, {$urandom, $urandom});
		repeat (8) @(posedge clk);
		#2;
		base_pulses = credit_pulses;
		check_value("producer credits", FIFO_DEPTH - sent_count + credit_pulses, 0);
		check_value("results before credit return", out_count - base_out, OUT_CREDITS);
		repeat (20) @(posedge clk);
		#2;
		check_value("in_credit pulses while full", credit_pulses, base_pulses);
		check_value("results while full", out_count - base_out, OUT_CREDITS);
		auto_credit = 1'b1;
		wait_drain();
	endtask

	task automatic run_credit_totals();
		check_value("in_credit pulses", credit_pulses, sent_count);
		check_value("results out", out_count, sent_count);
	endtask

	// ========================================
	// output monitor and consumer
	// ========================================
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (!reset)
			begin
				if (in_credit)
					credit_pulses++;
				if (out_valid)
				begin
					if (OUT_CREDITS + returned_count - out_count <= 0)
					begin
						$display("out_valid went high with no consumer credit left");
						err_count++;
					end
					out_count++;
					if (sb.size() == 0)
					begin
						$display("out_valid went high with no result outstanding");
						err_count++;
					end
					else
					begin
						exp_word = sb.pop_front();
						check_value("out_cond", 32'(out_cond), 32'(exp_word[COND_WIDTH-1:0]));
						check_value("out_nan", 32'(out_nan), 32'(exp_word[COND_WIDTH]));
						check_value("out_snan", 32'(out_snan), 32'(exp_word[COND_WIDTH+1]));
						check_value("out_cond reserved bits", 32'(out_cond & 16'hE0E0), 32'h0);
					end
				end
			end
		end
	end

	initial
	begin
		out_credit = 1'b0;
		forever
		begin
			@(posedge clk);
			#2;
			if (auto_credit && out_count > returned_count)
			begin
				out_credit = 1'b1;
				returned_count++;
			end
			else
				out_credit = 1'b0;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: tests still running after %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	// ========================================
	// main sequence
	// ========================================
	initial
	begin
		in_valid = 1'b0;
		a = '0;
		b = '0;
		status_clear = 1'b0;
		auto_credit = 1'b1;
		void'($urandom(RAND_SEED));
		@(negedge reset);
		@(posedge clk);
		#2;
		run_random();
		run_zeros();
		run_nans();
		run_backpressure();
		run_credit_totals();
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// free-running clock from time zero; reset is released 2 ns after the last reset edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// synchronous reset held for a fixed number of rising edges
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/fp_cmp_unit.sv
// producer must honour FIFO_DEPTH credits; consumer starts with OUT_CREDITS, no ready signals
`timescale 1ns/1ns
`default_nettype none

module fp_cmp_unit
#(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
)
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  fp64_pkg::fp64_word                a,
	input  fp64_pkg::fp64_word                b,
	input  logic                              out_credit,
	input  logic                              status_clear,
	output logic                              in_credit,
	output logic                              out_valid,
	output logic [fp64_pkg::COND_WIDTH-1:0]   out_cond,
	output logic                              out_nan,
	output logic                              out_snan,
	output logic                              nan_sticky,
	output logic                              snan_sticky
);
	import fp64_pkg::*;

	// stage 1 operand register
	logic     s1_valid;
	fp64_word s1_a;
	fp64_word s1_b;

	// comparator results for the stage 1 pair
	logic [COND_WIDTH-1:0] cmp_cond;
	logic                  cmp_nan;
	logic                  cmp_snan;

	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// operands held only when a pair arrives
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_a <= a;
			s1_b <= b;
		end
	end

	fp_compare64 u_cmp (.a(s1_a), .b(s1_b), .o(cmp_cond), .nan(cmp_nan), .snan(cmp_snan));

	fp_except_status u_status (.clk(clk), .reset(reset), .valid(s1_valid), .nan(cmp_nan),
		.snan(cmp_snan), .clear(status_clear), .nan_sticky(nan_sticky),
		.snan_sticky(snan_sticky));

	// result written at the edge after stage 1 loads
	fp_result_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_fifo (.clk(clk),
		.reset(reset), .wr_en(s1_valid), .wr_cond(cmp_cond), .wr_nan(cmp_nan),
		.wr_snan(cmp_snan), .out_credit(out_credit), .out_valid(out_valid),
		.out_cond(out_cond), .out_nan(out_nan), .out_snan(out_snan), .in_credit(in_credit));

endmodule

`default_nettype wire

// File: hdl/fp_except_status.sv
// sticky flags only change on valid compares; clear beats a set in the same cycle
`timescale 1ns/1ns
`default_nettype none

module fp_except_status
(
	input  logic clk,
	input  logic reset,
	input  logic valid,
	input  logic nan,
	input  logic snan,
	input  logic clear,
	output logic nan_sticky,
	output logic snan_sticky
);

	always_ff @(posedge clk)
	begin
		if (reset | clear)
		begin
			nan_sticky  <= 1'b0;
			snan_sticky <= 1'b0;
		end
		else if (valid)
		begin
			// accumulate, never drop a flag until cleared
			nan_sticky  <= nan_sticky | nan;
			snan_sticky <= snan_sticky | snan;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fp_result_fifo.sv
// FIFO_DEPTH must be a power of two >= 2; a write while full is dropped (producer out of credit)
`timescale 1ns/1ns
`default_nettype none

module fp_result_fifo
#(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
)
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              wr_en,
	input  logic [fp64_pkg::COND_WIDTH-1:0]   wr_cond,
	input  logic                              wr_nan,
	input  logic                              wr_snan,
	input  logic                              out_credit,
	output logic                              out_valid,
	output logic [fp64_pkg::COND_WIDTH-1:0]   out_cond,
	output logic                              out_nan,
	output logic                              out_snan,
	output logic                              in_credit
);
	import fp64_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	// wide enough for a consumer that returns credit well ahead of traffic
	localparam int CREDIT_W = 16;

	// entry storage, flags kept beside each condition word
	logic [COND_WIDTH-1:0] mem_cond [FIFO_DEPTH];
	logic                  mem_nan  [FIFO_DEPTH];
	logic                  mem_snan [FIFO_DEPTH];

	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic [CREDIT_W-1:0] credit;

	logic full;
	logic empty;
	logic do_wr;
	logic do_pop;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr_en & ~full;
	// one entry leaves per cycle while downstream credit remains
	assign do_pop = ~empty & (credit != '0);

	// ========================================
	// storage and output payload
	// ========================================
	always_ff @(posedge clk)
	begin
		if (do_wr)
		begin
			mem_cond[wr_ptr] <= wr_cond;
			mem_nan[wr_ptr]  <= wr_nan;
			mem_snan[wr_ptr] <= wr_snan;
		end
		// payload only meaningful while out_valid is high
		if (do_pop)
		begin
			out_cond <= mem_cond[rd_ptr];
			out_nan  <= mem_nan[rd_ptr];
			out_snan <= mem_snan[rd_ptr];
		end
	end

	// ========================================
	// pointers, occupancy and credit
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credit    <= CREDIT_W'(OUT_CREDITS);
			out_valid <= 1'b0;
			in_credit <= 1'b0;
		end
		else
		begin
			// pointers wrap on their own since depth is a power of two
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(do_wr) - CNT_W'(do_pop);
			// returned credit and a spend in the same cycle cancel out
			credit <= credit + CREDIT_W'(out_credit) - CREDIT_W'(do_pop);
			// each pop frees a slot, handed back upstream as one credit
			out_valid <= do_pop;
			in_credit <= do_pop;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fp_compare64.sv
// zero-cycle compare; lt/le/mlt are not masked by unordered, check the unordered bit first
`timescale 1ns/1ns
`default_nettype none

module fp_compare64
(
	input  fp64_pkg::fp64_word                  a,
	input  fp64_pkg::fp64_word                  b,
	output logic [fp64_pkg::COND_WIDTH-1:0]     o,
	output logic                                nan,
	output logic                                snan
);
	import fp64_pkg::*;

	// decomposed operand fields
	logic            sa, sb;
	logic [EMSB:0]   xa, xb;
	logic [FMSB:0]   ma, mb;
	logic            az, bz;
	logic            nan_a, nan_b;
	logic            snan_a, snan_b;

	// intermediate relations
	logic unordered;
	logic eq;
	logic lt;
	logic mag_lt;
	logic mag_gt;

	fp_decomp64 u_dec_a (.i(a), .sgn(sa), .exp(xa), .man(ma), .vz(az), .inf(),
		.nan(nan_a), .qnan(), .snan(snan_a));
	fp_decomp64 u_dec_b (.i(b), .sgn(sb), .exp(xb), .man(mb), .vz(bz), .inf(),
		.nan(nan_b), .qnan(), .snan(snan_b));

	assign unordered = nan_a | nan_b;

	// two zeros are equal whatever their signs
	assign eq = ~unordered & ((az & bz) | (a.raw == b.raw));

	// exponent above fraction, so one unsigned compare orders magnitudes
	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// signs differ: negative one is smaller, except -0 vs +0
	// same sign: magnitude order, flipped when both negative
	assign lt = (sa ^ sb) ? (sa & ~(az & bz)) : (sa ? mag_gt : mag_lt);

	// ========================================
	// condition word
	// ========================================
	always_comb
	begin
		o = '0;
		o[COND_EQ]  = eq;
		o[COND_LT]  = lt;
		o[COND_LE]  = lt | eq;
		o[COND_MLT] = mag_lt;
		o[COND_UN]  = unordered;
		// inverse copies in the upper byte
		o[COND_INV_OFS + COND_EQ]  = ~eq;
		o[COND_INV_OFS + COND_LT]  = ~lt;
		o[COND_INV_OFS + COND_LE]  = ~(lt | eq);
		o[COND_INV_OFS + COND_MLT] = ~mag_lt;
		o[COND_INV_OFS + COND_UN]  = ~unordered;
	end

	// any nan input raises nan, snan only for signaling ones
	assign nan  = unordered;
	assign snan = snan_a | snan_b;

endmodule

`default_nettype wire

// File: hdl/fp_decomp64.sv
// purely combinational; denormals are passed through untouched, nan kind taken from fraction msb
`timescale 1ns/1ns
`default_nettype none

module fp_decomp64
(
	input  fp64_pkg::fp64_word        i,
	output logic                      sgn,
	output logic [fp64_pkg::EMSB:0]   exp,
	output logic [fp64_pkg::FMSB:0]   man,
	output logic                      vz,
	output logic                      inf,
	output logic                      nan,
	output logic                      qnan,
	output logic                      snan
);
	import fp64_pkg::*;

	// field class helpers
	logic exp_ones;
	logic exp_zero;
	logic man_zero;

	// field split straight through the union view
	assign sgn = i.f.sign;
	assign exp = i.f.exp;
	assign man = i.f.man;

	assign exp_ones = &i.f.exp;
	assign exp_zero = ~|i.f.exp;
	assign man_zero = ~|i.f.man;

	// +0 and -0 both count as zero
	assign vz  = exp_zero & man_zero;
	// max exponent: infinity if fraction empty, nan otherwise
	assign inf = exp_ones & man_zero;
	assign nan = exp_ones & ~man_zero;
	// quiet nan has the top fraction bit set
	assign qnan = nan & i.f.man[FMSB];
	assign snan = nan & ~i.f.man[FMSB];

endmodule

`default_nettype wire

// File: hdl/fp64_pkg.sv
// binary64 only; condition word positions are fixed, and bits 5-7 and 13-15 are reserved zero
`default_nettype none

package fp64_pkg;

	// ========================================
	// operand format
	// ========================================
	localparam int FP_WIDTH  = 64;
	localparam int EXP_WIDTH = 11;
	localparam int MAN_WIDTH = 52;
	// top bit indexes of the exponent and fraction fields
	localparam int EMSB = EXP_WIDTH - 1;
	localparam int FMSB = MAN_WIDTH - 1;

	// ========================================
	// condition word layout
	// ========================================
	localparam int COND_WIDTH = 16;
	localparam int COND_EQ  = 0;
	localparam int COND_LT  = 1;
	localparam int COND_LE  = 2;
	// magnitude-lt ignores both signs
	localparam int COND_MLT = 3;
	localparam int COND_UN  = 4;
	// inverse of each flag sits this many bits higher
	localparam int COND_INV_OFS = 8;

	// one operand word, seen either as plain bits or as ieee fields
	typedef union packed
	{
		logic [FP_WIDTH-1:0] raw;
		struct packed
		{
			logic                 sign;
			logic [EXP_WIDTH-1:0] exp;
			logic [MAN_WIDTH-1:0] man;
		} f;
	} fp64_word;

endpackage

`default_nettype wire
